// ==== flist.f ====
common/isa_pkg.sv
common/pipe_pkg.sv
decode/inst_decoder.sv
decode/operand_mux.sv
hdl/id_ex_reg.sv
decode/id_stage.sv
verif/tb_id_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ID stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/100ps \
	--top-module tb_id_stage \
	-f flist.f

./obj_dir/Vtb_id_stage 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi

echo "simulation finished without failures"

// ==== verif/tb_id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int N_TESTS         = 6;
	localparam int WATCHDOG_CYCLES = N_TESTS * 20 + 100;
	localparam logic [1:0] EXT_ZERO = 2'd0;
	localparam logic [1:0] EXT_UP   = 2'd1;
	localparam logic [1:0] EXT_SIGN = 2'd2;

	logic    clk;
	logic    rst_n_i;
	logic    inst_valid_i;
	word_t   pc_i;
	inst_u   inst_i;
	logic    stall_i;
	wb_fwd_t ex_fwd_i;
	wb_fwd_t mem_fwd_i;
	word_t   rf1_data_i;
	word_t   rf2_data_i;
	rf_req_t rf1_req_o;
	rf_req_t rf2_req_o;
	id_ex_t  id_ex_o;

	word_t rf_mem [32];	// register-file model
	word_t pc_next;
	int    n_checks;
	int    n_errors;

	id_stage UUT (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.inst_valid_i (inst_valid_i),
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.stall_i      (stall_i),
		.ex_fwd_i     (ex_fwd_i),
		.mem_fwd_i    (mem_fwd_i),
		.rf1_data_i   (rf1_data_i),
		.rf2_data_i   (rf2_data_i),
		.rf1_req_o    (rf1_req_o),
		.rf2_req_o    (rf2_req_o),
		.id_ex_o      (id_ex_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// same-cycle read answer
	assign rf1_data_i = rf_mem[rf1_req_o.addr];
	assign rf2_data_i = rf_mem[rf2_req_o.addr];

	function automatic inst_u r_inst(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [4:0] shamt, logic [5:0] fn);
		return {OP_SPECIAL, rs, rt, rd, shamt, fn};
	endfunction

	function automatic inst_u i_inst(logic [5:0] opc, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm16);
		return {opc, rs, rt, imm16};
	endfunction

	function automatic id_ex_t bubble();
		id_ex_t b;
		b        = '0;
		b.alusel = SEL_NOP;
		b.aluop  = OP_NOP;
		return b;
	endfunction

	function automatic id_ex_t op_bundle(logic [ALUSEL_W-1:0] sel, logic [ALUOP_W-1:0] op,
		reg_addr_t wd, word_t r1, word_t r2, word_t pc);
		id_ex_t b;
		b        = bubble();
		b.valid  = 1'b1;
		b.wreg   = 1'b1;
		b.alusel = sel;
		b.aluop  = op;
		b.wd     = wd;
		b.reg1   = r1;
		b.reg2   = r2;
		b.pc     = pc;
		return b;
	endfunction

	task automatic check_field(string test_name, string field, word_t exp, word_t act);
		n_checks++;
		assert (act === exp)
		else begin
			n_errors++;
			$display("[FAIL] %s: %s expected %h actual %h", test_name, field, exp, act);
		end
	endtask

	// control fields always, data fields only for decoded instructions
	task automatic check_bundle(string test_name, id_ex_t exp, bit full);
		check_field(test_name, "valid", 32'(exp.valid), 32'(id_ex_o.valid));
		check_field(test_name, "illegal", 32'(exp.illegal), 32'(id_ex_o.illegal));
		check_field(test_name, "wreg", 32'(exp.wreg), 32'(id_ex_o.wreg));
		check_field(test_name, "alusel", 32'(exp.alusel), 32'(id_ex_o.alusel));
		check_field(test_name, "aluop", 32'(exp.aluop), 32'(id_ex_o.aluop));
		if (full) begin
			check_field(test_name, "wd", 32'(exp.wd), 32'(id_ex_o.wd));
			check_field(test_name, "reg1", exp.reg1, id_ex_o.reg1);
			check_field(test_name, "reg2", exp.reg2, id_ex_o.reg2);
			check_field(test_name, "pc", exp.pc, id_ex_o.pc);
		end
	endtask

	// drive at the falling edge, return one edge after it was registered
	task automatic issue(inst_u w);
		inst_i       = w;
		inst_valid_i = 1'b1;
		pc_i         = pc_next;
		pc_next      = pc_next + 32'd4;
		@(negedge clk);
	endtask

	task automatic test_reset_idle();
		word_t junk;
		check_bundle("reset", bubble(), 1'b0);
		inst_valid_i = 1'b0;
		for (int i = 0; i < 3; i++) begin
			junk   = $urandom;
			inst_i = junk;	// garbage on an idle slot
			@(negedge clk);
			check_bundle("idle", bubble(), 1'b0);
			check_field("idle", "rf1 re", 32'd0, 32'(rf1_req_o.re));
			check_field("idle", "rf2 re", 32'd0, 32'(rf2_req_o.re));
		end
	endtask

	task automatic test_rtype();
		logic [5:0]          fn  [10];
		logic [ALUSEL_W-1:0] sel [10];
		logic [ALUOP_W-1:0]  op  [10];
		reg_addr_t           rs, rt, rd;
		fn  = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
		sel = '{SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_ARITH,
			SEL_ARITH, SEL_ARITH, SEL_ARITH, SEL_ARITH, SEL_ARITH};
		op  = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU};
		for (int i = 0; i < 10; i++) begin
			rs = 5'($urandom);
			rt = 5'($urandom);
			rd = 5'($urandom);
			issue(r_inst(rs, rt, rd, 5'd0, fn[i]));
			check_bundle($sformatf("rtype %0d", i),
				op_bundle(sel[i], op[i], rd, rf_mem[rs], rf_mem[rt], pc_i), 1'b1);
		end
	endtask

	task automatic test_immediate();
		logic [5:0]          opc [8];
		logic [ALUSEL_W-1:0] sel [8];
		logic [ALUOP_W-1:0]  op  [8];
		logic [1:0]          ext [8];	// how imm16 widens
		reg_addr_t           rs, rt;
		logic [15:0]         imm16;
		word_t               imm;
		int                  k;
		opc = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI, isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU,
			isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU};
		sel = '{SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_LOGIC,
			SEL_ARITH, SEL_ARITH, SEL_ARITH, SEL_ARITH};
		op  = '{OP_AND, OP_OR, OP_XOR, OP_OR, pipe_pkg::OP_ADDI, pipe_pkg::OP_ADDIU,
			pipe_pkg::OP_SLTI, pipe_pkg::OP_SLTIU};
		ext = '{EXT_ZERO, EXT_ZERO, EXT_ZERO, EXT_UP, EXT_SIGN, EXT_SIGN, EXT_SIGN, EXT_SIGN};
		for (int i = 0; i < 16; i++) begin
			k         = i / 2;
			rs        = 5'($urandom);
			rt        = 5'($urandom);
			imm16     = 16'($urandom);
			imm16[15] = i[0];	// both signs for each kind
			if (ext[k] == EXT_ZERO)
				imm = {16'h0000, imm16};
			else if (ext[k] == EXT_UP)
				imm = {imm16, 16'h0000};
			else
				imm = {{16{imm16[15]}}, imm16};
			issue(i_inst(opc[k], rs, rt, imm16));
			check_bundle($sformatf("imm %0d", i),
				op_bundle(sel[k], op[k], rt, rf_mem[rs], imm, pc_i), 1'b1);
		end
	endtask

	task automatic test_shift();
		logic [5:0]         fn  [6];
		logic [ALUOP_W-1:0] op  [6];
		reg_addr_t          rs, rt, rd;
		logic [4:0]         sh;
		word_t              r1;
		fn = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
		op = '{OP_SLL, OP_SRL, OP_SRA, OP_SLL, OP_SRL, OP_SRA};
		for (int i = 0; i < 6; i++) begin
			rs = 5'($urandom);
			rt = 5'($urandom);
			rd = 5'($urandom);
			sh = (i < 3) ? 5'($urandom) : 5'd0;
			r1 = (i < 3) ? {27'd0, sh} : rf_mem[rs];	// fixed forms carry shamt
			issue(r_inst(rs, rt, rd, sh, fn[i]));
			check_bundle($sformatf("shift %0d", i),
				op_bundle(SEL_SHIFT, op[i], rd, r1, rf_mem[rt], pc_i), 1'b1);
		end
	endtask

	task automatic test_forwarding();
		reg_addr_t rs, rt, rd;
		word_t     ex_data;
		word_t     mem_data;
		rs       = 5'($urandom);
		rt       = rs ^ 5'd1;
		rd       = 5'($urandom);
		ex_data  = $urandom;
		mem_data = $urandom;

		ex_fwd_i  = '{1'b1, rs, ex_data};
		mem_fwd_i = '{1'b1, rs, mem_data};
		issue(r_inst(rs, rt, rd, 5'd0, FN_ADDU));
		check_bundle("fwd ex over mem",
			op_bundle(SEL_ARITH, OP_ADDU, rd, ex_data, rf_mem[rt], pc_i), 1'b1);

		ex_fwd_i = '{1'b1, rs ^ 5'd2, ex_data};	// execute writes elsewhere
		issue(r_inst(rs, rt, rd, 5'd0, FN_ADDU));
		check_bundle("fwd mem only",
			op_bundle(SEL_ARITH, OP_ADDU, rd, mem_data, rf_mem[rt], pc_i), 1'b1);

		ex_fwd_i  = '{1'b0, rs, ex_data};
		mem_fwd_i = '{1'b1, rs ^ 5'd2, mem_data};
		issue(r_inst(rs, rt, rd, 5'd0, FN_ADDU));
		check_bundle("fwd none",
			op_bundle(SEL_ARITH, OP_ADDU, rd, rf_mem[rs], rf_mem[rt], pc_i), 1'b1);

		ex_fwd_i = '{1'b1, rt, ex_data};	// second port forwards too
		issue(r_inst(rs, rt, rd, 5'd0, FN_ADDU));
		check_bundle("fwd port 2",
			op_bundle(SEL_ARITH, OP_ADDU, rd, rf_mem[rs], ex_data, pc_i), 1'b1);

		ex_fwd_i  = '0;
		mem_fwd_i = '0;
	endtask

	task automatic test_stall_illegal();
		reg_addr_t   rs, rt, rd;
		logic [15:0] imm16;
		word_t       junk;
		id_ex_t      held;
		id_ex_t      bad;
		rs    = 5'($urandom);
		rt    = 5'($urandom);
		rd    = 5'($urandom);
		imm16 = 16'($urandom);
		issue(i_inst(OP_ORI, rs, rt, imm16));
		held = op_bundle(SEL_LOGIC, OP_OR, rt, rf_mem[rs], {16'h0000, imm16}, pc_i);
		check_bundle("stall setup", held, 1'b1);

		stall_i = 1'b1;
		for (int i = 0; i < 4; i++) begin
			junk         = $urandom;
			inst_i       = junk;
			inst_valid_i = i[0];
			pc_i         = pc_i + 32'd4;
			@(negedge clk);
			check_bundle($sformatf("stall %0d", i), held, 1'b1);
		end
		stall_i = 1'b0;

		bad         = bubble();
		bad.valid   = 1'b1;
		bad.illegal = 1'b1;
		issue(i_inst(6'b111111, rs, rt, imm16));
		check_bundle("illegal opcode", bad, 1'b0);
		issue(r_inst(rs, rt, rd, 5'd0, 6'b111111));
		check_bundle("illegal funct", bad, 1'b0);
		inst_valid_i = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hcbd3_d36c));
		for (int i = 0; i < 32; i++)
			rf_mem[i] = $urandom;
		n_checks     = 0;
		n_errors     = 0;
		pc_next      = 32'h0000_1000;
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b1;	// live slot, only reset keeps it out
		pc_i         = '0;
		inst_i       = '0;
		stall_i      = 1'b0;
		ex_fwd_i     = '0;
		mem_fwd_i    = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n_i      = 1'b1;
		inst_valid_i = 1'b0;

		test_reset_idle();
		test_rtype();
		test_immediate();
		test_shift();
		test_forwarding();
		test_stall_illegal();

		$display("checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== decode/id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage (
	input  wire logic         clk,
	input  wire logic         rst_n_i,
	input  wire logic         inst_valid_i,
	input  isa_pkg::word_t    pc_i,
	input  isa_pkg::inst_u    inst_i,
	input  wire logic         stall_i,
	input  pipe_pkg::wb_fwd_t ex_fwd_i,
	input  pipe_pkg::wb_fwd_t mem_fwd_i,
	input  isa_pkg::word_t    rf1_data_i,
	input  isa_pkg::word_t    rf2_data_i,
	output pipe_pkg::rf_req_t rf1_req_o,
	output pipe_pkg::rf_req_t rf2_req_o,
	output pipe_pkg::id_ex_t  id_ex_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	id_ex_t dec;	// control half of the bundle
	id_ex_t id_next;
	word_t  imm;
	word_t  op1;
	word_t  op2;

	inst_decoder u_dec (
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.rf1_req_o    (rf1_req_o),
		.rf2_req_o    (rf2_req_o),
		.imm_o        (imm),
		.dec_o        (dec)
	);

	operand_mux u_op1 (
		.req_i     (rf1_req_o),
		.rf_data_i (rf1_data_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.imm_i     (imm),
		.operand_o (op1)
	);

	operand_mux u_op2 (
		.req_i     (rf2_req_o),
		.rf_data_i (rf2_data_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.imm_i     (imm),
		.operand_o (op2)
	);

	// merge operands and pc into the decoded bundle
	always_comb begin
		id_next      = dec;
		id_next.reg1 = op1;
		id_next.reg2 = op2;
		id_next.pc   = pc_i;
	end

	id_ex_reg u_id_ex (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.stall_i (stall_i),
		.next_i  (id_next),
		.id_ex_o (id_ex_o)
	);

endmodule

`default_nettype wire

// ==== hdl/id_ex_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg (
	input  wire logic        clk,
	input  wire logic        rst_n_i,
	input  wire logic        stall_i,
	input  pipe_pkg::id_ex_t next_i,
	output pipe_pkg::id_ex_t id_ex_o
);
	import pipe_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			id_ex_o        <= '0;	// bubble
			id_ex_o.alusel <= SEL_NOP;
			id_ex_o.aluop  <= OP_NOP;
		end else if (!stall_i) begin
			// an idle slot arrives here already as a NOP bundle
			id_ex_o <= next_i;
		end
	end

	// execute holds its inputs while the stage is frozen
	assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_i |=> $stable(id_ex_o))
		else $error("id_ex_o changed during stall");

	// decoder must never let an undefined opcode write back
	assert property (@(posedge clk) disable iff (!rst_n_i)
		id_ex_o.illegal |-> !id_ex_o.wreg)
		else $error("illegal instruction with wreg set");

	// a bubble carries no operation
	assert property (@(posedge clk) disable iff (!rst_n_i)
		!id_ex_o.valid |-> (id_ex_o.aluop == OP_NOP && !id_ex_o.wreg))
		else $error("invalid entry carries an operation");

endmodule

`default_nettype wire

// ==== decode/operand_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_mux (
	input  pipe_pkg::rf_req_t req_i,
	input  isa_pkg::word_t    rf_data_i,
	input  pipe_pkg::wb_fwd_t ex_fwd_i,
	input  pipe_pkg::wb_fwd_t mem_fwd_i,
	input  isa_pkg::word_t    imm_i,
	output isa_pkg::word_t    operand_o
);

	logic ex_hit;
	logic mem_hit;

	// no special case for $0, a later write to it still forwards
	assign ex_hit  = ex_fwd_i.we  && (ex_fwd_i.wd  == req_i.addr);
	assign mem_hit = mem_fwd_i.we && (mem_fwd_i.wd == req_i.addr);

	always_comb begin
		if (!req_i.re)
			operand_o = imm_i;	// port not read, immediate/shamt
		else if (ex_hit)
			operand_o = ex_fwd_i.wdata;	// youngest result wins
		else if (mem_hit)
			operand_o = mem_fwd_i.wdata;
		else
			operand_o = rf_data_i;
	end

endmodule

`default_nettype wire

// ==== decode/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
	input  wire logic       inst_valid_i,
	input  isa_pkg::inst_u  inst_i,
	output pipe_pkg::rf_req_t rf1_req_o,
	output pipe_pkg::rf_req_t rf2_req_o,
	output isa_pkg::word_t  imm_o,
	output pipe_pkg::id_ex_t dec_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// opcode and sub-op names overlap for the I-type arithmetic forms,
	// so those are always written with their package prefix

	logic [ALUSEL_W-1:0] sel;
	logic [ALUOP_W-1:0]  op;
	logic                known;
	logic                re1;
	logic                re2;
	reg_addr_t           wd;
	word_t               imm;
	logic [15:0]         imm16;

	assign imm16 = inst_i.i_fields.imm16;

	always_comb begin
		sel   = SEL_NOP;
		op    = OP_NOP;
		known = 1'b0;
		re1   = 1'b0;
		re2   = 1'b0;
		wd    = inst_i.i_fields.rt;	// I-type destination by default
		imm   = '0;

		case (inst_i.r_fields.op)
			OP_SPECIAL: begin
				known = 1'b1;
				re1   = 1'b1;
				re2   = 1'b1;
				wd    = inst_i.r_fields.rd;
				case (inst_i.r_fields.funct)
					FN_AND:  begin sel = SEL_LOGIC; op = OP_AND;  end
					FN_OR:   begin sel = SEL_LOGIC; op = OP_OR;   end
					FN_XOR:  begin sel = SEL_LOGIC; op = OP_XOR;  end
					FN_NOR:  begin sel = SEL_LOGIC; op = OP_NOR;  end
					FN_SLLV: begin sel = SEL_SHIFT; op = OP_SLL;  end
					FN_SRLV: begin sel = SEL_SHIFT; op = OP_SRL;  end
					FN_SRAV: begin sel = SEL_SHIFT; op = OP_SRA;  end
					FN_ADD:  begin sel = SEL_ARITH; op = OP_ADD;  end
					FN_ADDU: begin sel = SEL_ARITH; op = OP_ADDU; end
					FN_SUB:  begin sel = SEL_ARITH; op = OP_SUB;  end
					FN_SUBU: begin sel = SEL_ARITH; op = OP_SUBU; end
					FN_SLT:  begin sel = SEL_ARITH; op = OP_SLT;  end
					FN_SLTU: begin sel = SEL_ARITH; op = OP_SLTU; end
					FN_SLL, FN_SRL, FN_SRA: begin
						// shift amount comes from the word, not port 1
						sel = SEL_SHIFT;
						re1 = 1'b0;
						imm = {27'd0, inst_i.r_fields.shamt};
						if (inst_i.r_fields.funct == FN_SLL)
							op = OP_SLL;
						else if (inst_i.r_fields.funct == FN_SRL)
							op = OP_SRL;
						else
							op = OP_SRA;
					end
					default: known = 1'b0;
				endcase
			end
			isa_pkg::OP_ANDI: begin
				sel = SEL_LOGIC;
				op  = OP_AND;
				imm = {16'h0000, imm16};	// zero-extend
			end
			isa_pkg::OP_ORI: begin
				sel = SEL_LOGIC;
				op  = OP_OR;
				imm = {16'h0000, imm16};
			end
			isa_pkg::OP_XORI: begin
				sel = SEL_LOGIC;
				op  = OP_XOR;
				imm = {16'h0000, imm16};
			end
			isa_pkg::OP_LUI: begin
				sel = SEL_LOGIC;
				op  = OP_OR;	// rs | (imm << 16), rs is $0 in real code
				imm = {imm16, 16'h0000};
			end
			isa_pkg::OP_ADDI: begin
				sel = SEL_ARITH;
				op  = pipe_pkg::OP_ADDI;
				imm = {{16{imm16[15]}}, imm16};	// sign-extend
			end
			isa_pkg::OP_ADDIU: begin
				sel = SEL_ARITH;
				op  = pipe_pkg::OP_ADDIU;
				imm = {{16{imm16[15]}}, imm16};
			end
			isa_pkg::OP_SLTI: begin
				sel = SEL_ARITH;
				op  = pipe_pkg::OP_SLTI;
				imm = {{16{imm16[15]}}, imm16};
			end
			isa_pkg::OP_SLTIU: begin
				sel = SEL_ARITH;
				op  = pipe_pkg::OP_SLTIU;
				imm = {{16{imm16[15]}}, imm16};
			end
			default: ;
		endcase

		// every I-type case above reads rs and takes the immediate on port 2
		if (inst_i.r_fields.op != OP_SPECIAL && sel != SEL_NOP) begin
			known = 1'b1;
			re1   = 1'b1;
			re2   = 1'b0;
		end
	end

	always_comb begin
		dec_o         = '0;
		dec_o.alusel  = SEL_NOP;
		dec_o.aluop   = OP_NOP;
		dec_o.valid   = inst_valid_i;
		dec_o.illegal = inst_valid_i && !known;
		dec_o.wd      = wd;
		if (inst_valid_i && known) begin
			dec_o.alusel = sel;
			dec_o.aluop  = op;
			dec_o.wreg   = 1'b1;
		end
	end

	assign rf1_req_o.re   = inst_valid_i && known && re1;
	assign rf1_req_o.addr = inst_i.r_fields.rs;
	assign rf2_req_o.re   = inst_valid_i && known && re2;
	assign rf2_req_o.addr = inst_i.r_fields.rt;
	assign imm_o          = imm;

	// an idle slot must not reach the register file
	always_comb begin
		assert (inst_valid_i || !(rf1_req_o.re || rf2_req_o.re))
			else $error("read request issued without a valid instruction");
	end

endmodule

`default_nettype wire

// ==== common/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	localparam int ALUSEL_W = 3;
	localparam int ALUOP_W  = 8;

	// operation class, picks the result path in execute
	localparam logic [ALUSEL_W-1:0] SEL_NOP   = 3'b000;
	localparam logic [ALUSEL_W-1:0] SEL_LOGIC = 3'b001;
	localparam logic [ALUSEL_W-1:0] SEL_SHIFT = 3'b010;
	localparam logic [ALUSEL_W-1:0] SEL_ARITH = 3'b100;

	// sub-operations
	localparam logic [ALUOP_W-1:0] OP_NOP   = 8'b00000000;
	localparam logic [ALUOP_W-1:0] OP_AND   = 8'b00100100;
	localparam logic [ALUOP_W-1:0] OP_OR    = 8'b00100101;
	localparam logic [ALUOP_W-1:0] OP_XOR   = 8'b00100110;
	localparam logic [ALUOP_W-1:0] OP_NOR   = 8'b00100111;
	localparam logic [ALUOP_W-1:0] OP_SLL   = 8'b01111100;
	localparam logic [ALUOP_W-1:0] OP_SRL   = 8'b00000010;
	localparam logic [ALUOP_W-1:0] OP_SRA   = 8'b00000011;
	localparam logic [ALUOP_W-1:0] OP_ADD   = 8'b00100000;
	localparam logic [ALUOP_W-1:0] OP_ADDU  = 8'b00100001;
	localparam logic [ALUOP_W-1:0] OP_SUB   = 8'b00100010;
	localparam logic [ALUOP_W-1:0] OP_SUBU  = 8'b00100011;
	localparam logic [ALUOP_W-1:0] OP_SLT   = 8'b00101010;
	localparam logic [ALUOP_W-1:0] OP_SLTU  = 8'b00101011;
	localparam logic [ALUOP_W-1:0] OP_ADDI  = 8'b01010101;
	localparam logic [ALUOP_W-1:0] OP_ADDIU = 8'b01010110;
	localparam logic [ALUOP_W-1:0] OP_SLTI  = 8'b01010111;
	localparam logic [ALUOP_W-1:0] OP_SLTIU = 8'b01011000;

	typedef struct packed {
		logic              re;
		isa_pkg::reg_addr_t addr;
	} rf_req_t;

	// result a later stage is about to write back
	typedef struct packed {
		logic               we;
		isa_pkg::reg_addr_t wd;
		isa_pkg::word_t     wdata;
	} wb_fwd_t;

	typedef struct packed {
		logic                valid;
		logic                illegal;
		logic [ALUSEL_W-1:0] alusel;
		logic [ALUOP_W-1:0]  aluop;
		logic                wreg;	// write rd/rt after execute
		isa_pkg::reg_addr_t  wd;
		isa_pkg::word_t      reg1;
		isa_pkg::word_t      reg2;
		isa_pkg::word_t      pc;
	} id_ex_t;

endpackage

`default_nettype wire

// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// basic machine types
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] word_t;

	// register format: and, addu, sll ...
	typedef struct packed {
		logic [5:0] op;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	// immediate format: ori, addiu, lui ...
	typedef struct packed {
		logic [5:0]  op;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm16;
	} i_fields_t;

	// one fetched word, read as either format
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} inst_u;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;	// R-type, see funct
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	// funct codes under OP_SPECIAL
	// logic
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;

	// shift by shamt
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;

	// shift by rs
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;

	// arithmetic and compare
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

endpackage

`default_nettype wire
